// ==== front_end.f ====
+incdir+rtl
rtl/front_end_pkg.sv
rtl/btb_if.sv
rtl/btb.sv
rtl/branch_predictor.sv
rtl/pc_gen_stage.sv
rtl/fetch_stage.sv
rtl/front_end.sv
verification/icache_model.sv
verification/tb_front_end.sv

// ==== Bender.yml ====
package:
  name: front_end

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/front_end_pkg.sv
      - rtl/btb_if.sv
      - rtl/btb.sv
      - rtl/branch_predictor.sv
      - rtl/pc_gen_stage.sv
      - rtl/fetch_stage.sv
      - rtl/front_end.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/icache_model.sv
      - verification/tb_front_end.sv

// ==== verification/tb_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module tb_front_end;

  import front_end_pkg::*;

  typedef enum logic [1:0] {ACT_RUN, ACT_RESOLVE, ACT_EXCEPT, ACT_STALL} act_e;

  // One stimulus step
  // An exp_pc of zero leaves the first item to the model checks alone
  typedef struct {
    act_e        act;
    logic [31:0] pc;
    logic [31:0] target;
    logic        taken;
    logic        mispred;
    logic [31:0] epc;
    logic [31:0] exp_pc;
    logic        exp_hit;
    logic        exp_taken;
    int          count;
  } row_t;

  localparam int NROWS = 18;
  localparam logic [31:0] X = 32'h1040;
  localparam logic [31:0] Y = 32'h1200;
  localparam logic [31:0] Z = 32'h1084;
  localparam logic [31:0] W = 32'h1300;

  logic clk_i;
  logic arst_n_i;
  logic flush_i;
  logic [`XLEN-1:0] addr_o;
  logic addr_valid_o;
  logic addr_ready_i;
  logic [`ILEN-1:0] data_i;
  logic data_valid_i;
  logic data_ready_o;
  logic issue_ready_i;
  logic issue_valid_o;
  logic [`ILEN-1:0] instruction_o;
  prediction_t pred_o;
  resolution_t res_i;
  logic except_i;
  logic [`XLEN-1:0] except_pc_i;

  row_t rows [NROWS];
  // Issued items seen by the monitor
  prediction_t seen_pred [$];
  logic [`ILEN-1:0] seen_instr [$];
  logic stall_mode;
  logic [31:0] lcg_state;
  logic [31:0] rand_word;
  logic [`XLEN-1:0] exp_next;

  // Reference predictor state
  logic [1:0] m_ctr [2**`HLEN];
  logic [`HLEN-1:0] m_hist;
  logic m_valid [2**`BTB_BITS];
  logic [`XLEN-1:0] m_pc [2**`BTB_BITS];
  logic [`XLEN-1:0] m_tgt [2**`BTB_BITS];

  // Stall check state
  logic held;
  logic [`ILEN-1:0] held_instr;
  prediction_t held_pred;

  front_end dut_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .addr_o(addr_o), .addr_valid_o(addr_valid_o), .addr_ready_i(addr_ready_i),
    .data_i(data_i), .data_valid_i(data_valid_i), .data_ready_o(data_ready_o),
    .issue_ready_i(issue_ready_i), .issue_valid_o(issue_valid_o),
    .instruction_o(instruction_o), .pred_o(pred_o), .res_i(res_i),
    .except_i(except_i), .except_pc_i(except_pc_i)
  );

  icache_model #(.SEED(19)) u_icache (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .addr_i(addr_o), .addr_valid_i(addr_valid_o),
    .addr_ready_o(addr_ready_i), .data_o(data_i), .data_valid_o(data_valid_i),
    .data_ready_i(data_ready_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [95:0] got,
                             input logic [95:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // A model hit needs the exact pc stored in its slot
  function automatic logic model_hit(input logic [`XLEN-1:0] p);
    return m_valid[p[`BTB_BITS+1:2]] && (m_pc[p[`BTB_BITS+1:2]] == p);
  endfunction

  function automatic logic model_taken(input logic [`XLEN-1:0] p);
    return model_hit(p) && m_ctr[p[`HLEN+1:2] ^ m_hist][1];
  endfunction

  task automatic train_model(input logic [`XLEN-1:0] p, input logic tk,
                             input logic [`XLEN-1:0] tgt);
    logic [`HLEN-1:0] idx;
    idx = p[`HLEN+1:2] ^ m_hist;
    if (tk && m_ctr[idx] != 2'b11) m_ctr[idx] = m_ctr[idx] + 2'd1;
    if (!tk && m_ctr[idx] != 2'b00) m_ctr[idx] = m_ctr[idx] - 2'd1;
    m_hist = {m_hist[`HLEN-2:0], tk};
    if (tk) begin
      m_valid[p[`BTB_BITS+1:2]] = 1'b1;
      m_pc[p[`BTB_BITS+1:2]]    = p;
      m_tgt[p[`BTB_BITS+1:2]]   = tgt;
    end
  endtask

  task automatic fill_table();
    rows[0]  = '{ACT_RUN,     0, 0, 0, 0, 0,          32'h1000, 0, 0, 6};
    // Taken mispredicts of X fill the history with ones
    rows[1]  = '{ACT_RESOLVE, X, Y, 1, 1, 0,          Y,        0, 0, 3};
    rows[2]  = '{ACT_EXCEPT,  0, 0, 0, 0, X,          X,        1, 0, 3};
    rows[3]  = '{ACT_RESOLVE, X, Y, 1, 1, 0,          Y,        0, 0, 2};
    rows[4]  = '{ACT_RESOLVE, X, Y, 1, 1, 0,          Y,        0, 0, 2};
    rows[5]  = '{ACT_RESOLVE, X, Y, 1, 1, 0,          Y,        0, 0, 2};
    rows[6]  = '{ACT_EXCEPT,  0, 0, 0, 0, X,          X,        1, 0, 2};
    // Two more at a steady history train the counter
    rows[7]  = '{ACT_RESOLVE, X, Y, 1, 1, 0,          Y,        0, 0, 2};
    rows[8]  = '{ACT_RESOLVE, X, Y, 1, 1, 0,          Y,        0, 0, 2};
    rows[9]  = '{ACT_EXCEPT,  0, 0, 0, 0, X,          X,        1, 1, 4};
    // Z warms the counter X lands on after one not-taken
    rows[10] = '{ACT_RESOLVE, Z, W, 1, 1, 0,          W,        0, 0, 2};
    rows[11] = '{ACT_RESOLVE, X, Y, 0, 1, 0,          X + 4,    0, 0, 2};
    rows[12] = '{ACT_EXCEPT,  0, 0, 0, 0, X,          X,        1, 1, 2};
    rows[13] = '{ACT_RESOLVE, X, Y, 0, 1, 0,          X + 4,    0, 0, 2};
    rows[14] = '{ACT_EXCEPT,  0, 0, 0, 0, X,          X,        1, 0, 3};
    // Exception beats a mispredict in the same cycle
    rows[15] = '{ACT_EXCEPT,  X, Y, 1, 1, 32'h2000,   32'h2000, 0, 0, 3};
    rows[16] = '{ACT_STALL,   0, 0, 0, 0, 0,          0,        0, 0, 24};
    rows[17] = '{ACT_RUN,     0, 0, 0, 0, 0,          0,        0, 0, 4};
  endtask

  // Redirect rows drive flush for one cycle
  task automatic apply_redirect(input row_t r);
    logic res_on;
    res_on = (r.act == ACT_RESOLVE) || r.mispred;
    @(posedge clk_i);
    flush_i <= 1'b1;
    if (res_on) begin
      res_i <= '{valid: 1'b1, mispredict: 1'b1, taken: r.taken, pc: r.pc, target: r.target};
    end
    if (r.act == ACT_EXCEPT) begin
      except_i    <= 1'b1;
      except_pc_i <= r.epc;
    end
    @(posedge clk_i);
    flush_i  <= 1'b0;
    except_i <= 1'b0;
    res_i    <= '0;
    if (r.act == ACT_EXCEPT) exp_next = r.epc;
    else exp_next = r.taken ? r.target : r.pc + 32'd4;
    if (res_on) train_model(r.pc, r.taken, r.target);
    @(negedge clk_i);
  endtask

  task automatic consume_items(input row_t r);
    prediction_t p;
    logic [`ILEN-1:0] instr;
    logic hit;
    logic tk;
    stall_mode = (r.act == ACT_STALL);
    for (int i = 0; i < r.count; i++) begin
      while (seen_pred.size() == 0) @(negedge clk_i);
      p     = seen_pred.pop_front();
      instr = seen_instr.pop_front();
      hit   = model_hit(p.pc);
      tk    = model_taken(p.pc);
      check_value("pred_o.pc", p.pc, exp_next);
      if (i == 0 && r.exp_pc != 0) begin
        check_value("pred_o.pc", p.pc, r.exp_pc);
        check_value("pred_o.hit", p.hit, r.exp_hit);
        check_value("pred_o.taken", p.taken, r.exp_taken);
      end
      check_value("pred_o.hit", p.hit, hit);
      check_value("pred_o.taken", p.taken, tk);
      if (hit) check_value("pred_o.target", p.target, m_tgt[p.pc[`BTB_BITS+1:2]]);
      check_value("instruction_o", instr, p.pc ^ 32'hA5A5_0000);
      exp_next = tk ? m_tgt[p.pc[`BTB_BITS+1:2]] : p.pc + 32'd4;
    end
    stall_mode = 1'b0;
  endtask

  // Decode ready is random only in stall rows
  always @(posedge clk_i) begin
    if (stall_mode) begin
      rand_word = next_rand();
      issue_ready_i <= rand_word[20];
    end else begin
      issue_ready_i <= 1'b1;
    end
  end

  // Collects issued items and checks the buffer holds under stall
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (held && issue_valid_o) begin
        check_value("instruction_o", instruction_o, held_instr);
        check_value("pred_o", pred_o, held_pred);
      end
      // No new request goes out during a flush
      if (flush_i) begin
        check_value("addr_valid_o", addr_valid_o, 1'b0);
      end
      // A full buffer that decode does not take stalls the responses
      if (issue_valid_o && !issue_ready_i) begin
        check_value("data_ready_o", data_ready_o, 1'b0);
      end
      held       = issue_valid_o && !issue_ready_i && !flush_i;
      held_instr = instruction_o;
      held_pred  = pred_o;
      if (flush_i) begin
        seen_pred.delete();
        seen_instr.delete();
      end else if (issue_valid_o && issue_ready_i) begin
        seen_pred.push_back(pred_o);
        seen_instr.push_back(instruction_o);
      end
    end
  end

  initial begin
    repeat (NROWS * 50 + 200) @(posedge clk_i);
    $display("Run timed out waiting for issued instructions");
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

  initial begin
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    flush_i       = 1'b0;
    issue_ready_i = 1'b1;
    res_i         = '0;
    except_i      = 1'b0;
    except_pc_i   = '0;
    stall_mode    = 1'b0;
    held          = 1'b0;
    lcg_state     = 32'd19;
    exp_next      = `BOOT_PC;
    m_hist        = '0;
    for (int i = 0; i < 2**`HLEN; i++) m_ctr[i] = 2'b01;
    for (int i = 0; i < 2**`BTB_BITS; i++) m_valid[i] = 1'b0;
    fill_table();
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    // Fetch starts at the boot address with an empty buffer
    check_value("addr_valid_o", addr_valid_o, 1'b1);
    check_value("addr_o", addr_o, `BOOT_PC);
    check_value("issue_valid_o", issue_valid_o, 1'b0);
    check_value("data_ready_o", data_ready_o, 1'b1);
    for (int r = 0; r < NROWS; r++) begin
      if (rows[r].act == ACT_RESOLVE || rows[r].act == ACT_EXCEPT) apply_redirect(rows[r]);
      consume_items(rows[r]);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/icache_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module icache_model #(
  parameter int unsigned SEED = 19
) (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic [`XLEN-1:0]  addr_i,
  input  wire logic              addr_valid_i,
  output logic                   addr_ready_o,
  output logic [`ILEN-1:0]       data_o,
  output logic                   data_valid_o,
  input  wire logic              data_ready_i
);

  // Pending addresses and the cycle each one becomes ready
  logic [`XLEN-1:0] addr_q [$];
  int               due_q  [$];
  int               cycle;
  logic [31:0]      lcg_state;

  // Same recurrence as the testbench, own state
  function automatic int unsigned next_latency();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return 1 + (lcg_state[30:16] % 3);
  endfunction

  // Always takes addresses, the DUT limits itself to two
  assign addr_ready_o = 1'b1;

  initial begin
    lcg_state    = SEED;
    data_o       = '0;
    data_valid_o = 1'b0;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q.delete();
      due_q.delete();
      cycle = 0;
      data_valid_o <= 1'b0;
    end else begin
      cycle = cycle + 1;
      // Response taken by the DUT
      if (data_valid_o && data_ready_i) begin
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (addr_valid_i && addr_ready_o) begin
        addr_q.push_back(addr_i);
        due_q.push_back(cycle + next_latency());
      end
      // Present the oldest entry once its latency ran out
      if (addr_q.size() > 0 && due_q[0] <= cycle) begin
        data_valid_o <= 1'b1;
        data_o       <= addr_q[0] ^ 32'hA5A5_0000;
      end else begin
        data_valid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module front_end (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        flush_i,
  // Instruction cache
  output logic [`XLEN-1:0]                 addr_o,
  output logic                             addr_valid_o,
  input  wire logic                        addr_ready_i,
  input  wire logic [`ILEN-1:0]            data_i,
  input  wire logic                        data_valid_i,
  output logic                             data_ready_o,
  // Decode
  input  wire logic                        issue_ready_i,
  output logic                             issue_valid_o,
  output logic [`ILEN-1:0]                 instruction_o,
  output front_end_pkg::prediction_t       pred_o,
  // Branch unit
  input  wire front_end_pkg::resolution_t  res_i,
  // Exception redirect
  input  wire logic                        except_i,
  input  wire logic [`XLEN-1:0]            except_pc_i
);

  import front_end_pkg::*;

  logic [`XLEN-1:0] pc;
  logic             fetch_ready;
  // Prediction for the pc being requested now
  prediction_t      pred;

  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .pc_i          (pc),
    .fetch_ready_o (fetch_ready),
    .pred_o        (pred),
    .res_i         (res_i),
    .addr_o        (addr_o),
    .addr_valid_o  (addr_valid_o),
    .addr_ready_i  (addr_ready_i),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instruction_o (instruction_o),
    .issued_pred_o (pred_o)
  );

  // Resolution also trains the predictor inside fetch
  pc_gen_stage u_pc_gen_stage (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .except_i      (except_i),
    .except_pc_i   (except_pc_i),
    .res_i         (res_i),
    .pred_i        (pred),
    .fetch_ready_i (fetch_ready),
    .pc_o          (pc)
  );

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module fetch_stage (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        flush_i,
  // pc generator side
  input  wire logic [`XLEN-1:0]            pc_i,
  output logic                             fetch_ready_o,
  output front_end_pkg::prediction_t       pred_o,
  // Branch unit
  input  wire front_end_pkg::resolution_t  res_i,
  // Instruction cache
  output logic [`XLEN-1:0]                 addr_o,
  output logic                             addr_valid_o,
  input  wire logic                        addr_ready_i,
  input  wire logic [`ILEN-1:0]            data_i,
  input  wire logic                        data_valid_i,
  output logic                             data_ready_o,
  // Decode
  input  wire logic                        issue_ready_i,
  output logic                             issue_valid_o,
  output logic [`ILEN-1:0]                 instruction_o,
  output front_end_pkg::prediction_t       issued_pred_o
);

  import front_end_pkg::*;

  // Outstanding request queue, two entries, in order
  prediction_t q_pred [2];
  logic [1:0]  q_drop_q;
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  logic [1:0]  count_q;

  // Issue buffer
  logic        buf_valid_q;
  logic [`ILEN-1:0] buf_instr_q;
  prediction_t buf_pred_q;

  logic push;
  logic pop;
  logic fill;

  btb_if u_btb_if ();

  branch_predictor u_branch_predictor (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .pc_i     (pc_i),
    .res_i    (res_i),
    .pred_o   (pred_o),
    .btb_port (u_btb_if.predictor)
  );

  btb u_btb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .port     (u_btb_if.tbl)
  );

  // Request while the queue has room and no flush
  assign addr_o        = pc_i;
  assign addr_valid_o  = (count_q != 2'd2) && !flush_i;
  assign fetch_ready_o = addr_valid_o && addr_ready_i;
  assign push          = fetch_ready_o;

  // Accept a response only if the buffer is free or draining now
  assign data_ready_o  = !buf_valid_q || issue_ready_i;
  assign pop           = data_valid_i && data_ready_o;
  // Dropped or flushed responses are swallowed
  assign fill          = pop && !q_drop_q[rd_ptr_q] && !flush_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // Flush marks every outstanding request; no push happens then
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      q_drop_q <= 2'b00;
    end else if (flush_i) begin
      q_drop_q <= 2'b11;
    end else if (push) begin
      q_drop_q[wr_ptr_q] <= 1'b0;
    end
  end

  // Prediction saved at request time
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_pred[wr_ptr_q] <= pred_o;
    end
  end

  // Buffer state, fill wins over drain
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_valid_q <= 1'b0;
    end else if (flush_i) begin
      buf_valid_q <= 1'b0;
    end else if (fill) begin
      buf_valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  // Payload only changes on fill, so it holds under stall
  always_ff @(posedge clk_i) begin
    if (fill) begin
      buf_instr_q <= data_i;
      buf_pred_q  <= q_pred[rd_ptr_q];
    end
  end

  assign issue_valid_o = buf_valid_q;
  assign instruction_o = buf_instr_q;
  assign issued_pred_o = buf_pred_q;

endmodule

`default_nettype wire

// ==== rtl/pc_gen_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module pc_gen_stage (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        except_i,
  input  wire logic [`XLEN-1:0]            except_pc_i,
  input  wire front_end_pkg::resolution_t  res_i,
  input  wire front_end_pkg::prediction_t  pred_i,
  input  wire logic                        fetch_ready_i,
  output logic [`XLEN-1:0]                 pc_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] next_pc;

  // Next pc by priority, exception first
  always_comb begin
    next_pc = pc_q;
    if (except_i) begin
      next_pc = except_pc_i;
    end else if (res_i.valid && res_i.mispredict) begin
      // Recover on the real outcome
      next_pc = res_i.taken ? res_i.target : res_i.pc + `XLEN'd4;
    end else if (fetch_ready_i) begin
      // Cache took this pc, follow the prediction
      next_pc = pred_i.taken ? pred_i.target : pc_q + `XLEN'd4;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= `BOOT_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module branch_predictor (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic [`XLEN-1:0]            pc_i,
  input  wire front_end_pkg::resolution_t  res_i,
  output front_end_pkg::prediction_t       pred_o,
  btb_if.predictor                         btb_port
);

  localparam int unsigned COUNTERS = 2 ** `HLEN;

  // Global history, newest outcome in bit 0
  logic [`HLEN-1:0] hist_q;
  // Two-bit saturating counters, 2'b01 is weakly not-taken
  logic [1:0]       ctr_q [COUNTERS];

  logic [`HLEN-1:0] rd_idx;
  logic [`HLEN-1:0] upd_idx;

  // gshare index for lookup and for training
  assign rd_idx  = pc_i[`HLEN+1:2] ^ hist_q;
  assign upd_idx = res_i.pc[`HLEN+1:2] ^ hist_q;

  // BTB lookup on the current pc
  assign btb_port.lookup_pc = pc_i;

  // Only taken branches allocate a BTB entry
  assign btb_port.upd_valid  = res_i.valid && res_i.taken;
  assign btb_port.upd_pc     = res_i.pc;
  assign btb_port.upd_target = res_i.target;

  // Direction only counts on a BTB hit
  assign pred_o.pc     = pc_i;
  assign pred_o.hit    = btb_port.hit;
  assign pred_o.taken  = btb_port.hit && ctr_q[rd_idx][1];
  assign pred_o.target = btb_port.target;

  // Counter and history train at resolution only
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hist_q <= '0;
      ctr_q  <= '{default: 2'b01};
    end else if (res_i.valid) begin
      hist_q <= {hist_q[`HLEN-2:0], res_i.taken};
      // Saturate at both ends
      if (res_i.taken) begin
        if (ctr_q[upd_idx] != 2'b11) begin
          ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'd1;
        end
      end else if (ctr_q[upd_idx] != 2'b00) begin
        ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

module btb (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  btb_if.tbl        port
);

  localparam int unsigned ENTRIES = 2 ** `BTB_BITS;
  // Upper pc bits above the index and the byte offset
  localparam int unsigned TAG_W   = `XLEN - `BTB_BITS - 2;

  logic [ENTRIES-1:0]   valid_q;
  logic [TAG_W-1:0]     tag_q    [ENTRIES];
  logic [`XLEN-1:0]     target_q [ENTRIES];

  logic [`BTB_BITS-1:0] rd_idx;
  logic [TAG_W-1:0]     rd_tag;
  logic [`BTB_BITS-1:0] wr_idx;

  // Lookup split into index and tag
  assign rd_idx = port.lookup_pc[`BTB_BITS+1:2];
  assign rd_tag = port.lookup_pc[`XLEN-1:`BTB_BITS+2];
  assign wr_idx = port.upd_pc[`BTB_BITS+1:2];

  // Hit needs a valid entry with the same tag
  assign port.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign port.target = target_q[rd_idx];

  // All entries start invalid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (port.upd_valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target storage
  always_ff @(posedge clk_i) begin
    if (port.upd_valid) begin
      tag_q[wr_idx]    <= port.upd_pc[`XLEN-1:`BTB_BITS+2];
      target_q[wr_idx] <= port.upd_target;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/btb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_end_defines.svh"

interface btb_if;

  // Combinational lookup
  logic [`XLEN-1:0] lookup_pc;
  logic             hit;
  logic [`XLEN-1:0] target;

  // One-cycle write strobe, written at the next edge
  logic             upd_valid;
  logic [`XLEN-1:0] upd_pc;
  logic [`XLEN-1:0] upd_target;

  // Predictor side drives lookup and update
  modport predictor (output lookup_pc, upd_valid, upd_pc, upd_target, input hit, target);

  // Table side answers the lookup
  modport tbl (input lookup_pc, upd_valid, upd_pc, upd_target, output hit, target);

endinterface

`default_nettype wire

// ==== rtl/front_end_pkg.sv ====
`default_nettype none

`include "front_end_defines.svh"

package front_end_pkg;

  // Prediction attached to every fetched instruction
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    // BTB matched this pc
    logic             hit;
    // Hit and counter upper bit set
    logic             taken;
    // Only meaningful on a hit
    logic [`XLEN-1:0] target;
  } prediction_t;

  // Branch outcome from the execute stage
  typedef struct packed {
    logic             valid;
    // Outcome differs from the prediction that was issued
    logic             mispredict;
    logic             taken;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] target;
  } resolution_t;

endpackage

`default_nettype wire

// ==== rtl/front_end_defines.svh ====
`ifndef FRONT_END_DEFINES_SVH
`define FRONT_END_DEFINES_SVH

// Address and instruction widths
`define XLEN 32
`define ILEN 32

// Global history length, also the gshare index width
`define HLEN 4

// BTB index width (16 entries)
`define BTB_BITS 4

// First pc fetched after reset
`define BOOT_PC 32'h0000_1000

`endif
